/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbExecCore
FILELIST  ?= execCore.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j $(JOBS)

SOURCES := $(wildcard source/*.sv source/*.svh bench/*.sv bench/*.svh)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only if the pass line shows up in the output
run: $(BINARY)
	@out="$$(./$(BINARY))"; echo "$$out"; echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf $(BUILD_DIR)

/* bench/isaModel.svh */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// expected retire record and the redirect it causes
typedef struct packed {
    logic        valid;
    logic        we;
    logic        hasDest;
    logic [4:0]  rd;
    logic [31:0] data;
    logic [31:0] pc;
    logic        taken;
    logic [31:0] target;
} retireRecT;

logic [31:0] modelRegs [32];
logic [31:0] lfsr;

// galois lfsr, one step per bit taken
function automatic logic [31:0] drawBits(input int n);
    logic [31:0] val;
    logic        outBit;
    val = '0;
    for (int i = 0; i < n; i++) begin
        outBit = lfsr[0];
        lfsr = (lfsr >> 1) ^ (outBit ? 32'h8020_0003 : 32'h0);
        val = {val[30:0], outBit};
    end
    return val;
endfunction

function automatic logic [31:0] rTypeWord(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] iTypeWord(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] uTypeWord(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

function automatic logic [31:0] jTypeWord(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

function automatic logic [31:0] bTypeWord(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

// rv32i integer semantics by funct3
function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                       input logic [31:0] a, input logic [31:0] b);
    logic [31:0] res;
    case (f3)
        3'b000: res = alt ? a - b : a + b;
        3'b001: res = a << b[4:0];
        3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011: res = (a < b) ? 32'd1 : 32'd0;
        3'b100: res = a ^ b;
        3'b101: begin
            if (alt) begin
                res = $signed(a) >>> b[4:0];
            end else begin
                res = a >> b[4:0];
            end
        end
        3'b110: res = a | b;
        default: res = a & b;
    endcase
    return res;
endfunction

function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
    case (f3)
        3'b000: return a == b;
        3'b001: return a != b;
        3'b100: return $signed(a) < $signed(b);
        default: return $signed(a) >= $signed(b);
    endcase
endfunction

`endif

/* bench/tbExecCore.sv */
`timescale 1ns/1ps
`default_nettype none

`include "execCore_consts.svh"

module tbExecCore;

    logic                   clk;
    logic                   arstN;
    logic                   instrValid;
    logic [`XLEN-1:0]       instr;
    logic [`XLEN-1:0]       pc;
    logic                   stall;
    logic                   redirect;
    logic [`XLEN-1:0]       redirectPc;
    logic                   retireValid;
    logic                   retireWe;
    logic [`REG_ADDR_W-1:0] retireRd;
    logic [`XLEN-1:0]       retireData;
    logic [`XLEN-1:0]       retirePc;

    `include "isaModel.svh"

    // records in execute and writeback and the one accepted at the next edge
    retireRecT   inExec;
    retireRecT   inWb;
    retireRecT   nextRec;
    retireRecT   pendRec;
    logic [31:0] pendWord;
    logic        havePend;
    logic [31:0] fetchPc;
    int          errCount;
    int          acceptCount;
    int          retireCount;
    int          redirectCount;
    int          stallCount;
    int          cycles;

    execCore uut (
        .clk         (clk),
        .arstN       (arstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .pc          (pc),
        .stall       (stall),
        .redirect    (redirect),
        .redirectPc  (redirectPc),
        .retireValid (retireValid),
        .retireWe    (retireWe),
        .retireRd    (retireRd),
        .retireData  (retireData),
        .retirePc    (retirePc)
    );

    always #10 clk = ~clk;

    validOk: assert property (@(posedge clk) disable iff (!arstN)
        retireValid == inWb.valid)
        else begin
            errCount++;
            $display("MISMATCH %0t: retireValid %0b expected %0b", $time,
                     $sampled(retireValid), inWb.valid);
        end

    weOk: assert property (@(posedge clk) disable iff (!arstN)
        retireValid |-> retireWe == inWb.we)
        else begin
            errCount++;
            $display("MISMATCH %0t: retireWe %0b expected %0b", $time,
                     $sampled(retireWe), inWb.we);
        end

    destOk: assert property (@(posedge clk) disable iff (!arstN)
        retireValid && inWb.hasDest |-> retireRd == inWb.rd && retireData == inWb.data)
        else begin
            errCount++;
            $display("MISMATCH %0t: x%0d = %h expected x%0d = %h", $time,
                     $sampled(retireRd), $sampled(retireData), inWb.rd, inWb.data);
        end

    pcOk: assert property (@(posedge clk) disable iff (!arstN)
        retireValid |-> retirePc == inWb.pc)
        else begin
            errCount++;
            $display("MISMATCH %0t: retirePc %h expected %h", $time,
                     $sampled(retirePc), inWb.pc);
        end

    redirectOk: assert property (@(posedge clk) disable iff (!arstN)
        redirect == (inExec.valid && inExec.taken))
        else begin
            errCount++;
            $display("MISMATCH %0t: redirect %0b for pc %h", $time,
                     $sampled(redirect), inExec.pc);
        end

    targetOk: assert property (@(posedge clk) disable iff (!arstN)
        redirect |-> redirectPc == inExec.target)
        else begin
            errCount++;
            $display("MISMATCH %0t: redirectPc %h expected %h", $time,
                     $sampled(redirectPc), inExec.target);
        end

    // random instruction at the given pc and its expected record
    task automatic buildInstr(input logic [31:0] at, output logic [31:0] word,
                              output retireRecT rec);
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [31:0] imm;
        kind = 4'(drawBits(4));
        // only x0 to x7 so dependencies are frequent
        rd = 5'(drawBits(3));
        rs1 = 5'(drawBits(3));
        rs2 = 5'(drawBits(3));
        f3 = 3'(drawBits(3));
        alt = 1'(drawBits(1));
        rec = '0;
        rec.valid = 1'b1;
        rec.hasDest = 1'b1;
        rec.rd = rd;
        rec.pc = at;
        if (kind < 4'd5) begin
            alt = alt && (f3 == 3'b000 || f3 == 3'b101);
            word = rTypeWord(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'b0110011);
            rec.data = aluRef(f3, alt, modelRegs[rs1], modelRegs[rs2]);
        end else if (kind < 4'd9) begin
            imm = drawBits(12);
            imm = {{20{imm[11]}}, imm[11:0]};
            if (f3 == 3'b001 || f3 == 3'b101) begin
                alt = alt && (f3 == 3'b101);
                imm = {27'b0, imm[4:0]};
                word = rTypeWord(alt ? 7'h20 : 7'h00, imm[4:0], rs1, f3, rd, 7'b0010011);
            end else begin
                alt = 1'b0;
                word = iTypeWord(imm[11:0], rs1, f3, rd, 7'b0010011);
            end
            rec.data = aluRef(f3, alt, modelRegs[rs1], imm);
        end else if (kind < 4'd11) begin
            imm = drawBits(20) << 12;
            word = uTypeWord(imm[31:12], rd, (kind == 4'd9) ? 7'b0110111 : 7'b0010111);
            rec.data = (kind == 4'd9) ? imm : at + imm;
        end else if (kind == 4'd11) begin
            imm = drawBits(20);
            imm = {{11{imm[19]}}, imm[19:0], 1'b0};
            word = jTypeWord(imm[20:0], rd);
            rec.data = at + 32'd4;
            rec.taken = 1'b1;
            rec.target = at + imm;
        end else if (kind == 4'd12) begin
            imm = drawBits(12);
            imm = {{20{imm[11]}}, imm[11:0]};
            word = iTypeWord(imm[11:0], rs1, 3'b000, rd, 7'b1100111);
            rec.data = at + 32'd4;
            rec.taken = 1'b1;
            rec.target = (modelRegs[rs1] + imm) & ~32'd1;
        end else begin
            // beq, bne, blt, bge only
            f3 = {f3[2], 1'b0, f3[0]};
            imm = drawBits(12);
            imm = {{19{imm[11]}}, imm[11:0], 1'b0};
            word = bTypeWord(imm[12:0], rs2, rs1, f3);
            rec.hasDest = 1'b0;
            rec.taken = branchTaken(f3, modelRegs[rs1], modelRegs[rs2]);
            rec.target = at + imm;
        end
        rec.we = rec.hasDest && (rd != 5'd0);
    endtask

    // one fetch-side cycle just after the falling edge
    task automatic stepCycle(input logic feed);
        logic doStall;
        logic doValid;
        if (retireValid) begin
            retireCount++;
        end
        inWb = inExec;
        inExec = nextRec;
        nextRec = '0;
        doStall = (drawBits(2) == 32'd0);
        doValid = (drawBits(3) != 32'd0);
        stall = doStall;
        if (inExec.valid && inExec.taken) begin
            // wrong-path slot discarded by the redirect
            redirectCount++;
            instrValid = 1'b1;
            instr = drawBits(32);
            pc = inExec.pc + 32'd4;
        end else begin
            if (!havePend && feed) begin
                buildInstr(fetchPc, pendWord, pendRec);
                havePend = 1'b1;
            end
            instrValid = feed && havePend && doValid;
            instr = pendWord;
            pc = fetchPc;
            if (instrValid && doStall) begin
                stallCount++;
            end
            if (instrValid && !doStall) begin
                nextRec = pendRec;
                acceptCount++;
                havePend = 1'b0;
                if (pendRec.we) begin
                    modelRegs[pendRec.rd] = pendRec.data;
                end
                fetchPc = pendRec.taken ? pendRec.target : pendRec.pc + 32'd4;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        arstN = 1'b0;
        instrValid = 1'b0;
        instr = '0;
        pc = '0;
        stall = 1'b0;
        lfsr = 32'hffb8_3ac9;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        inExec = '0;
        inWb = '0;
        nextRec = '0;
        pendRec = '0;
        pendWord = '0;
        havePend = 1'b0;
        fetchPc = 32'h0000_1000;
        errCount = 0;
        acceptCount = 0;
        retireCount = 0;
        redirectCount = 0;
        stallCount = 0;

        repeat (10) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;

        // outputs stay quiet while idle after reset
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            stepCycle(1'b0);
        end

        cycles = 0;
        while (acceptCount < 500 && cycles < 5000) begin
            @(negedge clk);
            stepCycle(1'b1);
            cycles++;
        end
        if (acceptCount < 500) begin
            errCount++;
            $display("timed out with only %0d instructions accepted", acceptCount);
        end

        cycles = 0;
        while ((inWb.valid || inExec.valid || nextRec.valid) && cycles < 20) begin
            @(negedge clk);
            stepCycle(1'b0);
            cycles++;
        end
        if (inWb.valid || inExec.valid || nextRec.valid) begin
            errCount++;
            $display("timed out waiting for the pipeline to drain");
        end

        countOk: assert (retireCount == acceptCount)
            else begin
                errCount++;
                $display("MISMATCH %0t: %0d retired, %0d accepted", $time,
                         retireCount, acceptCount);
            end
        if (redirectCount == 0 || stallCount == 0) begin
            errCount++;
            $display("the stream never produced both a redirect and a stall");
        end

        $display("errors %0d, accepted %0d, retired %0d, redirects %0d, stalls %0d",
                 errCount, acceptCount, retireCount, redirectCount, stallCount);
        if (errCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* execCore.f */
+incdir+source
+incdir+bench
source/execCorePkg.sv
source/wbIf.sv
source/pipeReg.sv
source/instrDecoder.sv
source/regFile.sv
source/executeUnit.sv
source/writebackStage.sv
source/execCore.sv
bench/tbExecCore.sv

/* source/execCore.sv */
`timescale 1ns/1ps
`default_nettype none

`include "execCore_consts.svh"

module execCore (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   instrValid,
    input  logic [`XLEN-1:0]       instr,
    input  logic [`XLEN-1:0]       pc,
    input  logic                   stall,
    output logic                   redirect,
    output logic [`XLEN-1:0]       redirectPc,
    output logic                   retireValid,
    output logic                   retireWe,
    output logic [`REG_ADDR_W-1:0] retireRd,
    output logic [`XLEN-1:0]       retireData,
    output logic [`XLEN-1:0]       retirePc
);

    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`XLEN-1:0]       rs1Val;
    logic [`XLEN-1:0]       rs2Val;
    execCorePkg::idExT      decPayload;
    execCorePkg::idExT      exPayload;
    execCorePkg::exWbT      exResult;

    wbIf wbBus ();

    // a stalled or redirected decode slot becomes a bubble
    instrDecoder decoder (
        .instr      (instr),
        .pc         (pc),
        .rs1Val     (rs1Val),
        .rs2Val     (rs2Val),
        .instrValid (instrValid),
        .kill       (redirect || stall),
        .rs1        (rs1),
        .rs2        (rs2),
        .payload    (decPayload)
    );

    regFile regs (
        .clk    (clk),
        .arstN  (arstN),
        .rs1    (rs1),
        .rs2    (rs2),
        .rs1Val (rs1Val),
        .rs2Val (rs2Val),
        .wb     (wbBus.rf)
    );

    // the bubble keeps execute moving, so idEx never holds
    pipeReg #(
        .payloadT (execCorePkg::idExT)
    ) idEx (
        .clk   (clk),
        .arstN (arstN),
        .hold  (1'b0),
        .flush (redirect),
        .d     (decPayload),
        .q     (exPayload)
    );

    executeUnit execute (
        .ex         (exPayload),
        .wb         (wbBus.fwd),
        .result     (exResult),
        .redirect   (redirect),
        .redirectPc (redirectPc)
    );

    writebackStage writeback (
        .clk         (clk),
        .arstN       (arstN),
        .result      (exResult),
        .wb          (wbBus.src),
        .retireValid (retireValid),
        .retireWe    (retireWe),
        .retireRd    (retireRd),
        .retireData  (retireData),
        .retirePc    (retirePc)
    );

endmodule

`default_nettype wire

/* source/execCorePkg.sv */
`default_nettype none

`include "execCore_consts.svh"

package execCorePkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASSB
    } aluOpT;

    typedef enum logic [1:0] {
        SRCA_RS1,
        SRCA_PC,
        SRCA_ZERO
    } srcASelT;

    // link result is pc+4
    typedef enum logic {
        RES_ALU,
        RES_LINK
    } resultSelT;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_JAL,
        BR_JALR
    } brCondT;

    // decode to execute
    typedef struct packed {
        logic                   valid;
        logic                   regWrite;
        aluOpT                  aluOp;
        srcASelT                srcASel;
        logic                   useImm;
        resultSelT              resultSel;
        brCondT                 brCond;
        logic [`XLEN-1:0]       rs1Val;
        logic [`XLEN-1:0]       rs2Val;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       imm;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       pcPlus4;
    } idExT;

    // execute to writeback
    typedef struct packed {
        logic                   valid;
        logic                   regWrite;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       result;
        logic [`XLEN-1:0]       pc;
    } exWbT;

endpackage

`default_nettype wire

/* source/execCore_consts.svh */
`ifndef EXEC_CORE_CONSTS_SVH
`define EXEC_CORE_CONSTS_SVH

// data and pc width
`define XLEN 32

// register index width
`define REG_ADDR_W 5

`define NUM_REGS 32

`endif

/* source/executeUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "execCore_consts.svh"

module executeUnit (
    input  execCorePkg::idExT  ex,
    wbIf.fwd                   wb,
    output execCorePkg::exWbT  result,
    output logic               redirect,
    output logic [`XLEN-1:0]   redirectPc
);

    logic [`XLEN-1:0] fwdA;
    logic [`XLEN-1:0] fwdB;
    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] aluOut;
    logic [`XLEN-1:0] jalrSum;
    logic             taken;

    // bypass from the instruction now in writeback
    assign fwdA = (wb.wrEn && wb.rd != '0 && wb.rd == ex.rs1) ? wb.data : ex.rs1Val;
    assign fwdB = (wb.wrEn && wb.rd != '0 && wb.rd == ex.rs2) ? wb.data : ex.rs2Val;

    always_comb begin
        case (ex.srcASel)
            execCorePkg::SRCA_PC:   opA = ex.pc;
            execCorePkg::SRCA_ZERO: opA = '0;
            default:                opA = fwdA;
        endcase
    end

    assign opB = ex.useImm ? ex.imm : fwdB;

    always_comb begin
        case (ex.aluOp)
            execCorePkg::ALU_ADD:   aluOut = opA + opB;
            execCorePkg::ALU_SUB:   aluOut = opA - opB;
            execCorePkg::ALU_AND:   aluOut = opA & opB;
            execCorePkg::ALU_OR:    aluOut = opA | opB;
            execCorePkg::ALU_XOR:   aluOut = opA ^ opB;
            execCorePkg::ALU_SLT:   aluOut = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            execCorePkg::ALU_SLTU:  aluOut = {{(`XLEN-1){1'b0}}, opA < opB};
            execCorePkg::ALU_SLL:   aluOut = opA << opB[4:0];
            execCorePkg::ALU_SRL:   aluOut = opA >> opB[4:0];
            execCorePkg::ALU_SRA:   aluOut = $signed(opA) >>> opB[4:0];
            execCorePkg::ALU_PASSB: aluOut = opB;
            default:                aluOut = '0;
        endcase
    end

    always_comb begin
        case (ex.brCond)
            execCorePkg::BR_EQ:   taken = (fwdA == fwdB);
            execCorePkg::BR_NE:   taken = (fwdA != fwdB);
            execCorePkg::BR_LT:   taken = ($signed(fwdA) < $signed(fwdB));
            execCorePkg::BR_GE:   taken = ($signed(fwdA) >= $signed(fwdB));
            execCorePkg::BR_JAL,
            execCorePkg::BR_JALR: taken = 1'b1;
            default:              taken = 1'b0;
        endcase
    end

    // jalr drops bit 0 of the sum
    assign jalrSum = fwdA + ex.imm;
    assign redirectPc = (ex.brCond == execCorePkg::BR_JALR) ? {jalrSum[`XLEN-1:1], 1'b0}
                                                          : ex.pc + ex.imm;
    assign redirect = ex.valid && taken;

    always_comb begin
        result = '0;
        result.valid = ex.valid;
        result.regWrite = ex.regWrite;
        result.rd = ex.rd;
        result.pc = ex.pc;
        if (ex.resultSel == execCorePkg::RES_LINK) begin
            result.result = ex.pcPlus4;
        end else begin
            result.result = aluOut;
        end
    end

    // a jump that writes rd writes the link value
    always_comb begin
        if (ex.valid && ex.regWrite && ex.brCond != execCorePkg::BR_NONE) begin
            assert (ex.resultSel == execCorePkg::RES_LINK)
                else $error("jump writes rd without the link value");
        end
    end

endmodule

`default_nettype wire

/* source/instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "execCore_consts.svh"

module instrDecoder (
    input  logic [`XLEN-1:0]       instr,
    input  logic [`XLEN-1:0]       pc,
    input  logic [`XLEN-1:0]       rs1Val,
    input  logic [`XLEN-1:0]       rs2Val,
    input  logic                   instrValid,
    input  logic                   kill,
    output logic [`REG_ADDR_W-1:0] rs1,
    output logic [`REG_ADDR_W-1:0] rs2,
    output execCorePkg::idExT      payload
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       immI;
    logic [`XLEN-1:0]       immB;
    logic [`XLEN-1:0]       immU;
    logic [`XLEN-1:0]       immJ;
    logic                   legal;
    logic                   checkFunct7;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        legal = 1'b1;
        checkFunct7 = 1'b0;
        payload = '0;
        payload.aluOp = execCorePkg::ALU_ADD;
        payload.srcASel = execCorePkg::SRCA_RS1;
        payload.resultSel = execCorePkg::RES_ALU;
        payload.brCond = execCorePkg::BR_NONE;
        payload.rs1Val = rs1Val;
        payload.rs2Val = rs2Val;
        payload.rs1 = rs1;
        payload.rs2 = rs2;
        payload.rd = rd;
        payload.pc = pc;
        payload.pcPlus4 = pc + 4;

        case (opcode)
            OPC_OP, OPC_OPIMM: begin
                payload.regWrite = 1'b1;
                payload.useImm = (opcode == OPC_OPIMM);
                payload.imm = immI;
                // funct7 is immediate bits for non-shift op-imm
                checkFunct7 = (opcode == OPC_OP) || (funct3 == 3'b001) || (funct3 == 3'b101);
                case (funct3)
                    3'b000: begin
                        if (opcode == OPC_OP && funct7[5]) begin
                            payload.aluOp = execCorePkg::ALU_SUB;
                        end else begin
                            payload.aluOp = execCorePkg::ALU_ADD;
                        end
                    end
                    3'b001: payload.aluOp = execCorePkg::ALU_SLL;
                    3'b010: payload.aluOp = execCorePkg::ALU_SLT;
                    3'b011: payload.aluOp = execCorePkg::ALU_SLTU;
                    3'b100: payload.aluOp = execCorePkg::ALU_XOR;
                    3'b101: begin
                        if (funct7[5]) begin
                            payload.aluOp = execCorePkg::ALU_SRA;
                        end else begin
                            payload.aluOp = execCorePkg::ALU_SRL;
                        end
                    end
                    3'b110: payload.aluOp = execCorePkg::ALU_OR;
                    default: payload.aluOp = execCorePkg::ALU_AND;
                endcase
                if (checkFunct7) begin
                    legal = (funct7 == 7'h00) ||
                            (funct7 == 7'h20 &&
                             (funct3 == 3'b101 || (opcode == OPC_OP && funct3 == 3'b000)));
                end
            end
            OPC_LUI: begin
                payload.regWrite = 1'b1;
                payload.srcASel = execCorePkg::SRCA_ZERO;
                payload.useImm = 1'b1;
                payload.imm = immU;
            end
            OPC_AUIPC: begin
                payload.regWrite = 1'b1;
                payload.srcASel = execCorePkg::SRCA_PC;
                payload.useImm = 1'b1;
                payload.imm = immU;
            end
            OPC_JAL: begin
                payload.regWrite = 1'b1;
                payload.resultSel = execCorePkg::RES_LINK;
                payload.brCond = execCorePkg::BR_JAL;
                payload.imm = immJ;
            end
            OPC_JALR: begin
                payload.regWrite = 1'b1;
                payload.resultSel = execCorePkg::RES_LINK;
                payload.brCond = execCorePkg::BR_JALR;
                payload.imm = immI;
                legal = (funct3 == 3'b000);
            end
            OPC_BRANCH: begin
                payload.imm = immB;
                case (funct3)
                    3'b000: payload.brCond = execCorePkg::BR_EQ;
                    3'b001: payload.brCond = execCorePkg::BR_NE;
                    3'b100: payload.brCond = execCorePkg::BR_LT;
                    3'b101: payload.brCond = execCorePkg::BR_GE;
                    default: legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase

        // writes to x0 never reach writeback
        payload.regWrite = payload.regWrite && (rd != '0);
        payload.valid = instrValid && !kill && legal;
    end

    // no subtract-immediate in rv32i
    always_comb begin
        if (payload.valid && payload.useImm) begin
            assert (payload.aluOp != execCorePkg::ALU_SUB)
                else $error("valid payload carries a subtract with an immediate");
        end
    end

endmodule

`default_nettype wire

/* source/pipeReg.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    hold,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    // flush beats hold
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

/* source/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "execCore_consts.svh"

module regFile (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic [`REG_ADDR_W-1:0] rs1,
    input  logic [`REG_ADDR_W-1:0] rs2,
    output logic [`XLEN-1:0]       rs1Val,
    output logic [`XLEN-1:0]       rs2Val,
    wbIf.rf                        wb
);

    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic             hit1;
    logic             hit2;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.wrEn) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // same-cycle write passes straight through
    assign hit1 = wb.wrEn && (wb.rd == rs1);
    assign hit2 = wb.wrEn && (wb.rd == rs2);

    assign rs1Val = (rs1 == '0) ? '0 : (hit1 ? wb.data : regs[rs1]);
    assign rs2Val = (rs2 == '0) ? '0 : (hit2 ? wb.data : regs[rs2]);

    x0Stays0: assert property (@(posedge clk) disable iff (!arstN) regs[0] == '0)
        else $error("x0 holds a nonzero value");

endmodule

`default_nettype wire

/* source/wbIf.sv */
`timescale 1ns/1ps
`default_nettype none

`include "execCore_consts.svh"

interface wbIf;

    logic                   wrEn;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       data;
    logic [`XLEN-1:0]       pc;

    // writeback stage owns the bus
    modport src (
        output wrEn, rd, data, pc
    );

    modport rf (
        input wrEn, rd, data
    );

    // forwarding into execute
    modport fwd (
        input wrEn, rd, data
    );

endinterface

`default_nettype wire

/* source/writebackStage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "execCore_consts.svh"

module writebackStage (
    input  logic                   clk,
    input  logic                   arstN,
    input  execCorePkg::exWbT      result,
    wbIf.src                       wb,
    output logic                   retireValid,
    output logic                   retireWe,
    output logic [`REG_ADDR_W-1:0] retireRd,
    output logic [`XLEN-1:0]       retireData,
    output logic [`XLEN-1:0]       retirePc
);

    execCorePkg::exWbT wbQ;

    // never stalls, never flushed
    pipeReg #(
        .payloadT (execCorePkg::exWbT)
    ) exWb (
        .clk   (clk),
        .arstN (arstN),
        .hold  (1'b0),
        .flush (1'b0),
        .d     (result),
        .q     (wbQ)
    );

    assign wb.wrEn = wbQ.valid && wbQ.regWrite;
    assign wb.rd   = wbQ.rd;
    assign wb.data = wbQ.result;
    assign wb.pc   = wbQ.pc;

    // retire port mirrors the bus
    assign retireValid = wbQ.valid;
    assign retireWe    = wb.wrEn;
    assign retireRd    = wbQ.rd;
    assign retireData  = wbQ.result;
    assign retirePc    = wb.pc;

endmodule

`default_nettype wire
